/* ipv4_header_parser.f */
source/ipv4_hdr_pkg.sv
source/parse_ctrl_if.sv
source/header_parse_fsm.sv
source/header_byte_counter.sv
source/header_field_capture.sv
source/payload_forward.sv
source/ipv4_header_parser.sv
test/ipv4_header_parser_assert.sv
test/ipv4_header_parser_tb.sv

/* Bender.yml */
package:
  name: ipv4_header_parser

sources:
  - files:
      - source/ipv4_hdr_pkg.sv
      - source/parse_ctrl_if.sv
      - source/header_parse_fsm.sv
      - source/header_byte_counter.sv
      - source/header_field_capture.sv
      - source/payload_forward.sv
      - source/ipv4_header_parser.sv
  - target: test
    files:
      - test/ipv4_header_parser_assert.sv
      - test/ipv4_header_parser_tb.sv

/* test/ipv4_header_parser_tb.sv */
/* Directed testbench for the IPv4 header parser. Stops at the first mismatch,
   expected headers and payload bytes are kept in scoreboard queues. */

`timescale 1ns/100ps

module ipv4_header_parser_tb import ipv4_hdr_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int TOTAL_BYTES  = 228;
    localparam int STALL_FACTOR = 8;
    localparam int DRAIN_CYCLES = 200;

    logic  clock;
    logic  rst_n;
    byte_t in_data;
    logic  in_valid;
    logic  in_last;
    logic  in_ready;
    byte_t out_data;
    logic  out_valid;
    logic  out_last;
    logic  out_ready;
    logic  hdr_valid;
    wire ipv4_fields_t dut_fields;

    // Scoreboard and stimulus state
    integer       seed;
    int           ready_mode;
    byte_t        exp_data[$];
    logic         exp_last[$];
    ipv4_fields_t exp_hdr[$];

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    ipv4_header_parser dut0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .in_ready     (in_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_ready    (out_ready),
        .hdr_valid    (hdr_valid),
        .version_ihl  (dut_fields.version_ihl),
        .tos          (dut_fields.tos),
        .total_length (dut_fields.total_length),
        .ident        (dut_fields.ident),
        .flags_frag   (dut_fields.flags_frag),
        .ttl          (dut_fields.ttl),
        .protocol     (dut_fields.protocol),
        .checksum     (dut_fields.checksum),
        .src_addr     (dut_fields.src_addr),
        .dst_addr     (dut_fields.dst_addr)
    );

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    task automatic report_failure();
        $display("Finished with errors");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic compare_byte(input byte_t exp_d, input logic exp_l,
                                input byte_t got_d, input logic got_l);
        if (got_d !== exp_d || got_l !== exp_l) begin
            $display("[FAIL] out_data/out_last: expected %h/%h, got %h/%h",
                     exp_d, exp_l, got_d, got_l);
            report_failure();
        end
    endtask

    task automatic compare_fields(input ipv4_fields_t exp, input ipv4_fields_t got);
        if (got !== exp) begin
            $display("[FAIL] header fields: expected %h, got %h", exp, got);
            if (got.total_length !== exp.total_length)
                $display("[FAIL] total_length: expected %h, got %h",
                         exp.total_length, got.total_length);
            if (got.src_addr !== exp.src_addr)
                $display("[FAIL] src_addr: expected %h, got %h", exp.src_addr, got.src_addr);
            if (got.dst_addr !== exp.dst_addr)
                $display("[FAIL] dst_addr: expected %h, got %h", exp.dst_addr, got.dst_addr);
            report_failure();
        end
    endtask

    // Field layout in wire order, most significant byte first
    function automatic ipv4_fields_t expected_fields(input byte_t frame[$]);
        ipv4_fields_t f;
        f.version_ihl  = frame[0];
        f.tos          = frame[1];
        f.total_length = {frame[2], frame[3]};
        f.ident        = {frame[4], frame[5]};
        f.flags_frag   = {frame[6], frame[7]};
        f.ttl          = frame[8];
        f.protocol     = frame[9];
        f.checksum     = {frame[10], frame[11]};
        f.src_addr     = {frame[12], frame[13], frame[14], frame[15]};
        f.dst_addr     = {frame[16], frame[17], frame[18], frame[19]};
        return f;
    endfunction

    // Sampled mid low phase, all outputs settled until the next rising edge
    always @(negedge clock) begin
        #1;
        if (rst_n) begin
            if (hdr_valid) begin
                if (exp_hdr.size() == 0) begin
                    $display("Header strobe seen while no header was expected");
                    report_failure();
                end else begin
                    compare_fields(exp_hdr.pop_front(), dut_fields);
                end
            end
            if (out_valid && out_ready) begin
                if (exp_data.size() == 0) begin
                    $display("Output byte %h seen while no payload was expected", out_data);
                    report_failure();
                end else begin
                    compare_byte(exp_data.pop_front(), exp_last.pop_front(),
                                 out_data, out_last);
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    // Mode 0 always ready, 1 random stalls, 2 held low
    always @(negedge clock) begin
        case (ready_mode)
            1:       out_ready = ({$random(seed)} % 4) != 0;
            2:       out_ready = 1'b0;
            default: out_ready = 1'b1;
        endcase
    end

    task automatic push_byte(input byte_t data, input logic last);
        @(negedge clock);
        in_valid = 1'b1;
        in_data  = data;
        in_last  = last;
        #1;
        while (!in_ready) begin
            @(negedge clock);
            #1;
        end
    endtask

    task automatic send_frame(input byte_t frame[$]);
        if (frame.size() >= HDR_BYTES)
            exp_hdr.push_back(expected_fields(frame));
        for (int i = HDR_BYTES; i < frame.size(); i++) begin
            exp_data.push_back(frame[i]);
            exp_last.push_back(i == frame.size() - 1);
        end
        for (int i = 0; i < frame.size(); i++)
            push_byte(frame[i], i == frame.size() - 1);
    endtask

    task automatic finish_input();
        @(negedge clock);
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_hdr.size() != 0 || exp_data.size() != 0 || out_valid) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > DRAIN_CYCLES) begin
                $display("Stream did not drain, %0d headers and %0d bytes still missing",
                         exp_hdr.size(), exp_data.size());
                report_failure();
            end
        end
        repeat (4) @(posedge clock);
    endtask

    task automatic append_header(inout byte_t frame[$], input byte_t base);
        for (int i = 0; i < HDR_BYTES; i++)
            frame.push_back(base + byte_t'(i * 13));
    endtask

    task automatic append_payload(inout byte_t frame[$], input int len);
        for (int i = 0; i < len; i++)
            frame.push_back(byte_t'($random(seed)));
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_header_decode();
        logic [159:0] known;
        byte_t        frame[$];
        known = 160'h4500_001a_1234_4000_4011_abcd_c0a8_010a_c0a8_0114;
        for (int i = 0; i < HDR_BYTES; i++)
            frame.push_back(known[159 - 8 * i -: 8]);
        append_payload(frame, 6);
        send_frame(frame);
        finish_input();
        wait_drain();
    endtask

    task automatic test_payload_pass();
        byte_t frame[$];
        append_header(frame, 8'h10);
        append_payload(frame, 10);
        send_frame(frame);
        finish_input();
        wait_drain();
    endtask

    task automatic test_back_pressure();
        byte_t frame[$];
        append_header(frame, 8'h37);
        append_payload(frame, 40);
        ready_mode = 1;
        send_frame(frame);
        finish_input();
        wait_drain();
        ready_mode = 0;
    endtask

    task automatic test_short_frame();
        byte_t cut[$];
        byte_t frame[$];
        append_header(cut, 8'h5a);
        cut = cut[0:11];
        send_frame(cut);
        append_header(frame, 8'h61);
        append_payload(frame, 4);
        send_frame(frame);
        finish_input();
        wait_drain();
    endtask

    task automatic test_exact_length();
        byte_t frame[$];
        append_header(frame, 8'h83);
        send_frame(frame);
        finish_input();
        wait_drain();
    endtask

    // Second header absorbed while the first frame's last byte waits
    task automatic test_back_to_back();
        byte_t frame_a[$];
        byte_t frame_b[$];
        append_header(frame_a, 8'h21);
        append_payload(frame_a, 8);
        append_header(frame_b, 8'hc4);
        append_payload(frame_b, 8);
        send_frame(frame_a);
        ready_mode = 2;
        fork
            send_frame(frame_b);
            begin
                repeat (HDR_BYTES + 4) @(posedge clock);
                #1;
                // Header of frame b decoded, last byte of frame a still held
                if (exp_hdr.size() != 0 || !out_valid) begin
                    $display("Second header not absorbed while the output was stalled");
                    report_failure();
                end else begin
                    ready_mode = 0;
                end
            end
        join
        finish_input();
        wait_drain();
    endtask

    initial begin
        #((TOTAL_BYTES * STALL_FACTOR + 200) * CLK_PERIOD);
        $display("Watchdog expired before all tests completed");
        report_failure();
    end

    initial begin
        seed       = 82705;
        ready_mode = 0;
        rst_n      = 1'b0;
        in_data    = '0;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        out_ready  = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        test_header_decode();
        test_payload_pass();
        test_back_pressure();
        test_short_frame();
        test_exact_length();
        test_back_to_back();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* test/ipv4_header_parser_assert.sv */
/* Protocol assertions for the parser outputs, bound to the top level.
   Only output-side rules are checked here. */

`timescale 1ns/100ps

module ipv4_header_parser_assert import ipv4_hdr_pkg::*; (
    input logic  clock,
    input logic  rst_n,
    input logic  hdr_valid,
    input byte_t out_data,
    input logic  out_valid,
    input logic  out_last,
    input logic  out_ready
);

    // Header strobe is a single cycle pulse
    hdr_single_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        hdr_valid |=> !hdr_valid)
        else $error("hdr_valid high for two cycles in a row");

    // Stalled output byte must not change
    out_hold_stable: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("out_data or out_last changed while stalled");

    out_reset_low: assert property (@(posedge clock)
        !rst_n |-> !out_valid && !hdr_valid)
        else $error("out_valid or hdr_valid high during reset");

endmodule

bind ipv4_header_parser ipv4_header_parser_assert assert0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .hdr_valid (hdr_valid),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready)
);

/* source/ipv4_header_parser.sv */
/* Streaming IPv4 header parser, one byte per cycle. The first 20 bytes of
   each frame are decoded as the header, the rest is passed through. */

`timescale 1ns/100ps

module ipv4_header_parser import ipv4_hdr_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,

    // Input stream
    input  byte_t       in_data,
    input  logic        in_valid,
    input  logic        in_last,
    output logic        in_ready,

    // Payload stream
    output byte_t       out_data,
    output logic        out_valid,
    output logic        out_last,
    input  logic        out_ready,

    // Parsed header
    output logic        hdr_valid,
    output logic [7:0]  version_ihl,
    output logic [7:0]  tos,
    output logic [15:0] total_length,
    output logic [15:0] ident,
    output logic [15:0] flags_frag,
    output logic [7:0]  ttl,
    output logic [7:0]  protocol,
    output logic [15:0] checksum,
    output logic [31:0] src_addr,
    output logic [31:0] dst_addr
);

    ipv4_fields_t fields;

    parse_ctrl_if ctrl ();

    // ----------------------------------------------------------------------
    // Control path
    // ----------------------------------------------------------------------
    header_parse_fsm fsm0 (
        .clock     (clock),
        .rst_n     (rst_n),
        .ctrl      (ctrl.fsm),
        .hdr_valid (hdr_valid)
    );

    header_byte_counter #(
        .LIMIT (HDR_BYTES)
    ) counter0 (
        .clock (clock),
        .rst_n (rst_n),
        .ctrl  (ctrl.counter)
    );

    // ----------------------------------------------------------------------
    // Data path
    // ----------------------------------------------------------------------
    header_field_capture capture0 (
        .clock  (clock),
        .rst_n  (rst_n),
        .ctrl   (ctrl.capture),
        .fields (fields)
    );

    payload_forward forward0 (
        .clock     (clock),
        .rst_n     (rst_n),
        .ctrl      (ctrl.forward),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    // Named field outputs
    assign version_ihl  = fields.version_ihl;
    assign tos          = fields.tos;
    assign total_length = fields.total_length;
    assign ident        = fields.ident;
    assign flags_frag   = fields.flags_frag;
    assign ttl          = fields.ttl;
    assign protocol     = fields.protocol;
    assign checksum     = fields.checksum;
    assign src_addr     = fields.src_addr;
    assign dst_addr     = fields.dst_addr;

endmodule

/* source/payload_forward.sv */
/* Input ready and a one-entry output register for payload bytes. Header
   bytes are always taken, payload waits for room in the output register. */

`timescale 1ns/100ps

module payload_forward import ipv4_hdr_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    parse_ctrl_if.forward ctrl,
    input  byte_t         in_data,
    input  logic          in_valid,
    input  logic          in_last,
    output logic          in_ready,
    output byte_t         out_data,
    output logic          out_valid,
    output logic          out_last,
    input  logic          out_ready
);

    logic accept;
    logic load_payload;

    // ----------------------------------------------------------------------
    // Input side
    // ----------------------------------------------------------------------
    // Output register free, or draining this cycle
    assign in_ready = ctrl.in_header || !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    assign ctrl.byte_accept = accept;
    assign ctrl.byte_last   = in_last;
    assign ctrl.byte_data   = in_data;

    assign load_payload = accept && !ctrl.in_header;

    // ----------------------------------------------------------------------
    // Output register
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load_payload) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Data and last only move with a new payload byte
    always_ff @(posedge clock) begin
        if (load_payload) begin
            out_data <= in_data;
            out_last <= in_last;
        end
    end

endmodule

/* source/header_field_capture.sv */
/* Header register written byte by byte. Fields of a frame stay valid until
   the first header byte of the next frame overwrites byte 0. */

`timescale 1ns/100ps

module header_field_capture import ipv4_hdr_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    parse_ctrl_if.capture ctrl,
    output ipv4_fields_t  fields
);

    ipv4_hdr_u hdr;
    logic      hdr_write;

    assign hdr_write = ctrl.byte_accept && ctrl.in_header;

    // ----------------------------------------------------------------------
    // Byte write through the raw view
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            hdr.raw <= '0;
        end else if (hdr_write) begin
            // Index never passes the last header byte
            hdr.raw[ctrl.byte_index] <= ctrl.byte_data;
        end
    end

    // Decoded view straight out
    assign fields = hdr.fields;

endmodule

/* source/header_byte_counter.sv */
/* Counts header bytes of the current frame. LIMIT must be between 1 and
   2**CNT_WIDTH. */

`timescale 1ns/100ps

module header_byte_counter import ipv4_hdr_pkg::*; #(
    parameter int LIMIT = HDR_BYTES
) (
    input  logic          clock,
    input  logic          rst_n,
    parse_ctrl_if.counter ctrl
);

    localparam byte_idx_t LAST_INDEX = byte_idx_t'(LIMIT - 1);

    byte_idx_t count;
    logic      at_limit;

    // Terminal flag, qualified with the accept by its users
    assign at_limit        = (count == LAST_INDEX);
    assign ctrl.header_end = at_limit;
    assign ctrl.byte_index = count;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (ctrl.byte_accept && ctrl.in_header) begin
            if (at_limit || ctrl.byte_last) begin
                // Header done or frame cut short
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

/* source/header_parse_fsm.sv */
/* Frame FSM. A frame whose last byte arrives before the header is complete
   is dropped without a header strobe. */

`timescale 1ns/100ps

module header_parse_fsm import ipv4_hdr_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    parse_ctrl_if.fsm  ctrl,
    output logic       hdr_valid
);

    parse_state_t state;
    parse_state_t state_next;
    logic         header_phase;

    // Idle counts as header phase, the first byte is already a header byte
    assign header_phase   = (state != ST_PAYLOAD);
    assign ctrl.in_header = header_phase;

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE, ST_HEADER: begin
                if (ctrl.byte_accept) begin
                    if (ctrl.byte_last) begin
                        // Short frame, or exact length with no payload
                        state_next = ST_IDLE;
                    end else if (ctrl.header_end) begin
                        state_next = ST_PAYLOAD;
                    end else begin
                        state_next = ST_HEADER;
                    end
                end
            end
            ST_PAYLOAD: begin
                if (ctrl.byte_accept && ctrl.byte_last) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ----------------------------------------------------------------------
    // Header strobe
    // ----------------------------------------------------------------------
    // One cycle after the last header byte, also when that byte ends the frame
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            hdr_valid <= 1'b0;
        end else begin
            hdr_valid <= ctrl.byte_accept && header_phase && ctrl.header_end;
        end
    end

endmodule

/* source/parse_ctrl_if.sv */
/* Internal control bundle of the header parser. Carries no clock, every
   signal is sampled on the parser clock by the module that reads it. */

`timescale 1ns/100ps

interface parse_ctrl_if import ipv4_hdr_pkg::*; ();

    // Input handshake as seen by the internal blocks
    logic      byte_accept;
    logic      byte_last;
    byte_t     byte_data;

    // Frame position
    logic      in_header;
    byte_idx_t byte_index;
    logic      header_end;

    modport fsm (
        input  byte_accept,
        input  byte_last,
        input  header_end,
        output in_header
    );

    modport counter (
        input  byte_accept,
        input  byte_last,
        input  in_header,
        output byte_index,
        output header_end
    );

    modport capture (
        input  byte_accept,
        input  byte_data,
        input  in_header,
        input  byte_index
    );

    modport forward (
        input  in_header,
        output byte_accept,
        output byte_last,
        output byte_data
    );

endinterface

/* source/ipv4_hdr_pkg.sv */
/* Types and constants for the IPv4 header parser. Options are not parsed,
   the header is always taken as 20 bytes in network byte order. */

package ipv4_hdr_pkg;

    // Stream data and header geometry
    typedef logic [7:0] byte_t;

    localparam int HDR_BYTES = 20;
    localparam int CNT_WIDTH = 5;

    typedef logic [CNT_WIDTH-1:0] byte_idx_t;

    // ----------------------------------------------------------------------
    // Header fields in wire order, first field in the top bits
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [7:0]  version_ihl;
        logic [7:0]  tos;
        logic [15:0] total_length;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
    } ipv4_fields_t;

    // Same 160 bits seen as arrival-order bytes, byte 0 most significant
    typedef union packed {
        byte_t [0:HDR_BYTES-1] raw;
        ipv4_fields_t          fields;
    } ipv4_hdr_u;

    // ----------------------------------------------------------------------
    // Frame state
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_HEADER  = 2'd1,
        ST_PAYLOAD = 2'd2
    } parse_state_t;

endpackage
